// File: compile.f
+incdir+include
design/i3c_rx_pkg.sv
design/bus_monitor.sv
design/target_rx_engine.sv
design/rx_byte_fifo.sv
design/rx_descriptor_builder.sv
design/i3c_target_rx.sv
tests/i3c_target_rx_sva.sv
tests/rx_checker.sv
tests/tb_i3c_target_rx.sv

// File: design/bus_monitor.sv
// Synchronizes SCL and SDA and reports their edges and START/STOP as single-cycle pulses
`timescale 1ns/100ps
`include "i3c_rx_cfg.svh"

module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_det_o,
  output logic stop_det_o,
  output logic sda_o
);

  logic [`SYNC_STAGES-1:0] scl_sync_q;
  logic [`SYNC_STAGES-1:0] sda_sync_q;
  logic                    scl_s;
  logic                    sda_s;
  logic                    scl_q;
  logic                    sda_q;

  assign scl_s = scl_sync_q[`SYNC_STAGES-1];
  assign sda_s = sda_sync_q[`SYNC_STAGES-1];

  // Idle bus is pulled high, so everything resets to one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[`SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[`SYNC_STAGES-2:0], sda_i};
      scl_q      <= scl_s;
      sda_q      <= sda_s;
    end
  end

  // Pulses registered so they line up with the delayed levels
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_rise_o  <= 1'b0;
      scl_fall_o  <= 1'b0;
      start_det_o <= 1'b0;
      stop_det_o  <= 1'b0;
    end else begin
      scl_rise_o  <= scl_s & ~scl_q;
      scl_fall_o  <= ~scl_s & scl_q;
      // SDA moving while SCL stays high
      start_det_o <= scl_s & scl_q & sda_q & ~sda_s;
      stop_det_o  <= scl_s & scl_q & ~sda_q & sda_s;
    end
  end

  assign sda_o = sda_q;

endmodule

// File: design/i3c_rx_pkg.sv
// Types shared by the I3C target receive path; import in the module body where used
`include "i3c_rx_cfg.svh"

package i3c_rx_pkg;

  // One byte on its way from the bus to the data port
  typedef struct packed {
    logic [`I3C_BYTE_W-1:0] data;
    logic                   last;
    logic                   parity_err;
    logic                   overflow;   // Only meaningful with last
  } rx_entry_t;

  // Per-frame report, byte count in the low half
  typedef struct packed {
    logic [13:0]            reserved;
    logic                   overflow;
    logic                   parity_err;
    logic [`RX_COUNT_W-1:0] byte_count;
  } rx_desc_t;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AddrAck,
    Data,
    Ignore
  } rx_state_e;

  typedef enum logic {
    Forward,
    Report
  } desc_state_e;

endpackage

// File: design/i3c_target_rx.sv
// Top level of the I3C SDR target receive path, pins in, byte stream and descriptors out
`timescale 1ns/100ps
`include "i3c_rx_cfg.svh"

module i3c_target_rx (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   scl_i,
  input  logic                   sda_i,
  output logic                   sda_o,
  input  logic [`I3C_ADDR_W-1:0] dyn_addr_i,
  input  logic                   dyn_addr_valid_i,
  output logic                   rx_data_valid_o,
  output logic [`I3C_BYTE_W-1:0] rx_data_o,
  input  logic                   rx_data_ready_i,
  output logic                   rx_desc_valid_o,
  output i3c_rx_pkg::rx_desc_t   rx_desc_o,
  input  logic                   rx_desc_ready_i
);

  import i3c_rx_pkg::*;

  logic      scl_rise;
  logic      scl_fall;
  logic      start_det;
  logic      stop_det;
  logic      sda_sync;
  logic      push_valid;
  logic      push_ready;
  rx_entry_t push_entry;
  logic      pop_valid;
  logic      pop_ready;
  rx_entry_t pop_entry;

  bus_monitor u_bus_monitor (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_rise_o (scl_rise),
    .scl_fall_o (scl_fall),
    .start_det_o(start_det),
    .stop_det_o (stop_det),
    .sda_o      (sda_sync)
  );

  target_rx_engine u_target_rx_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dyn_addr_i      (dyn_addr_i),
    .dyn_addr_valid_i(dyn_addr_valid_i),
    .scl_rise_i      (scl_rise),
    .scl_fall_i      (scl_fall),
    .start_det_i     (start_det),
    .stop_det_i      (stop_det),
    .sda_i           (sda_sync),
    .sda_o           (sda_o),
    .push_valid_o    (push_valid),
    .push_entry_o    (push_entry),
    .push_ready_i    (push_ready)
  );

  rx_byte_fifo #(
    .DEPTH(`RX_FIFO_DEPTH)
  ) u_rx_byte_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_valid_i(push_valid),
    .push_entry_i(push_entry),
    .push_ready_o(push_ready),
    .pop_valid_o (pop_valid),
    .pop_entry_o (pop_entry),
    .pop_ready_i (pop_ready)
  );

  rx_descriptor_builder u_rx_descriptor_builder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pop_valid_i    (pop_valid),
    .pop_entry_i    (pop_entry),
    .pop_ready_o    (pop_ready),
    .rx_data_valid_o(rx_data_valid_o),
    .rx_data_o      (rx_data_o),
    .rx_data_ready_i(rx_data_ready_i),
    .rx_desc_valid_o(rx_desc_valid_o),
    .rx_desc_o      (rx_desc_o),
    .rx_desc_ready_i(rx_desc_ready_i)
  );

endmodule

// File: design/rx_byte_fifo.sv
// Circular buffer of receive entries between the bus engine and the descriptor builder
`timescale 1ns/100ps
`include "i3c_rx_cfg.svh"

module rx_byte_fifo #(
  parameter int unsigned DEPTH = `RX_FIFO_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_valid_i,
  input  i3c_rx_pkg::rx_entry_t push_entry_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output i3c_rx_pkg::rx_entry_t pop_entry_o,
  input  logic                  pop_ready_i
);

  import i3c_rx_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  rx_entry_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign push_ready_o = (count_q != DEPTH[PTR_W:0]);
  assign pop_valid_o  = (count_q != '0);
  assign pop_entry_o  = mem_q[rd_ptr_q];

  assign do_push = push_valid_i && push_ready_o;
  assign do_pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at DEPTH, not at a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: design/rx_descriptor_builder.sv
// Drains the byte FIFO onto the data port and reports each frame with one descriptor
`timescale 1ns/100ps
`include "i3c_rx_cfg.svh"

module rx_descriptor_builder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   pop_valid_i,
  input  i3c_rx_pkg::rx_entry_t  pop_entry_i,
  output logic                   pop_ready_o,
  output logic                   rx_data_valid_o,
  output logic [`I3C_BYTE_W-1:0] rx_data_o,
  input  logic                   rx_data_ready_i,
  output logic                   rx_desc_valid_o,
  output i3c_rx_pkg::rx_desc_t   rx_desc_o,
  input  logic                   rx_desc_ready_i
);

  import i3c_rx_pkg::*;

  desc_state_e            state_q;
  logic                   data_valid_q;
  logic [`I3C_BYTE_W-1:0] data_q;
  logic [`RX_COUNT_W-1:0] count_q;
  logic                   parity_q;
  logic                   ovf_q;
  logic                   take;

  // Refill the output register when it is empty or being taken
  assign pop_ready_o = (state_q == Forward) && (!data_valid_q || rx_data_ready_i);
  assign take        = pop_valid_i && pop_ready_o;

  // Descriptor only once the last byte has left the data port
  assign rx_desc_valid_o = (state_q == Report) && !data_valid_q;

  always_ff @(posedge clk_i) begin
    if (take) begin
      data_q <= pop_entry_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Forward;
      data_valid_q <= 1'b0;
      count_q      <= '0;
      parity_q     <= 1'b0;
      ovf_q        <= 1'b0;
    end else begin
      if (take) begin
        data_valid_q <= 1'b1;
        count_q      <= count_q + 1'b1;
        parity_q     <= parity_q | pop_entry_i.parity_err;
        ovf_q        <= ovf_q | (pop_entry_i.last & pop_entry_i.overflow);
        if (pop_entry_i.last) begin
          state_q <= Report;
        end
      end else if (rx_data_ready_i) begin
        data_valid_q <= 1'b0;
      end

      if (rx_desc_valid_o && rx_desc_ready_i) begin
        state_q  <= Forward;
        count_q  <= '0;
        parity_q <= 1'b0;
        ovf_q    <= 1'b0;
      end
    end
  end

  assign rx_data_valid_o = data_valid_q;
  assign rx_data_o       = data_q;

  always_comb begin
    rx_desc_o            = '0;
    rx_desc_o.byte_count = count_q;
    rx_desc_o.parity_err = parity_q;
    rx_desc_o.overflow   = ovf_q;
  end

endmodule

// File: design/target_rx_engine.sv
// Receive FSM of the I3C target: address match, ACK, data and T-bit capture, FIFO push
`timescale 1ns/100ps
`include "i3c_rx_cfg.svh"

module target_rx_engine (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`I3C_ADDR_W-1:0] dyn_addr_i,
  input  logic                   dyn_addr_valid_i,
  input  logic                   scl_rise_i,
  input  logic                   scl_fall_i,
  input  logic                   start_det_i,
  input  logic                   stop_det_i,
  input  logic                   sda_i,
  output logic                   sda_o,
  output logic                   push_valid_o,
  output i3c_rx_pkg::rx_entry_t  push_entry_o,
  input  logic                   push_ready_i
);

  import i3c_rx_pkg::*;

  rx_state_e              state_q;
  logic [3:0]             bit_cnt_q;
  logic [`I3C_BYTE_W-1:0] shift_q;
  logic                   ack_q;
  logic                   addr_match;
  rx_entry_t              stage_q;
  logic                   stage_valid_q;
  rx_entry_t              push_entry_q;
  logic                   push_valid_q;
  logic                   frame_ovf_q;

  // Private write to our own dynamic address
  assign addr_match = dyn_addr_valid_i && !shift_q[0] &&
                      (shift_q[`I3C_BYTE_W-1:1] == dyn_addr_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      bit_cnt_q     <= '0;
      shift_q       <= '0;
      ack_q         <= 1'b0;
      stage_valid_q <= 1'b0;
      push_valid_q  <= 1'b0;
      frame_ovf_q   <= 1'b0;
    end else begin
      // SCL cannot be stretched, so a refused byte is lost
      // The last byte waits, nothing new arrives before the FIFO drains
      if (push_valid_q) begin
        if (push_ready_i) begin
          push_valid_q <= 1'b0;
        end else if (!push_entry_q.last) begin
          push_valid_q <= 1'b0;
          frame_ovf_q  <= 1'b1;
        end
      end

      if (start_det_i || stop_det_i) begin
        ack_q     <= 1'b0;
        bit_cnt_q <= '0;
        state_q   <= start_det_i ? Addr : Idle;
        // Frame ends here, flush staged byte as last
        if (stage_valid_q) begin
          push_valid_q  <= 1'b1;
          push_entry_q  <= '{data: stage_q.data, last: 1'b1,
                             parity_err: stage_q.parity_err, overflow: frame_ovf_q};
          stage_valid_q <= 1'b0;
        end
        frame_ovf_q <= 1'b0;
      end else begin
        case (state_q)
          Addr: begin
            if (scl_rise_i && bit_cnt_q != 4'd8) begin
              shift_q   <= {shift_q[`I3C_BYTE_W-2:0], sda_i};
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (scl_fall_i && bit_cnt_q == 4'd8) begin
              bit_cnt_q <= '0;
              if (addr_match) begin
                ack_q   <= 1'b1;
                state_q <= AddrAck;
              end else begin
                state_q <= Ignore;
              end
            end
          end

          AddrAck: begin
            // Hold SDA low through the 9th clock
            if (scl_fall_i) begin
              ack_q   <= 1'b0;
              state_q <= Data;
            end
          end

          Data: begin
            if (scl_rise_i) begin
              shift_q <= {shift_q[`I3C_BYTE_W-2:0], sda_i};
              if (bit_cnt_q == 4'd8) begin
                bit_cnt_q <= '0;
                // T bit makes the 9-bit word odd
                stage_q       <= '{data: shift_q, last: 1'b0,
                                   parity_err: (sda_i == ^shift_q), overflow: 1'b0};
                stage_valid_q <= 1'b1;
                if (stage_valid_q) begin
                  push_valid_q <= 1'b1;
                  push_entry_q <= stage_q;
                end
              end else begin
                bit_cnt_q <= bit_cnt_q + 4'd1;
              end
            end
          end

          default: ;
        endcase
      end
    end
  end

  assign sda_o        = ~ack_q;
  assign push_valid_o = push_valid_q;
  assign push_entry_o = push_entry_q;

endmodule

// File: include/i3c_rx_cfg.svh
// Width, depth and bus constants shared by the I3C target receive path; include where needed
`ifndef I3C_RX_CFG_SVH
`define I3C_RX_CFG_SVH

// Bus symbols
`define I3C_BYTE_W 8
`define I3C_ADDR_W 7

// Receive buffering
`define RX_FIFO_DEPTH 8

// Descriptor byte counter
`define RX_COUNT_W 16

// Pin synchronizer length
`define SYNC_STAGES 2

`endif

// File: run.sh
#!/bin/sh
# Build and run the receive path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_i3c_target_rx -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "^RESULT: PASS$" sim.log

// File: tests/i3c_target_rx_sva.sv
// Handshake and open-drain assertions, bound onto the receive path top level
`timescale 1ns/100ps

module i3c_target_rx_sva (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     sda_o_i,
  input logic                     scl_fall_i,
  input logic                     start_det_i,
  input logic                     stop_det_i,
  input logic                     rx_data_valid_i,
  input logic                     rx_data_ready_i,
  input logic [7:0]               rx_data_i,
  input logic                     rx_desc_valid_i,
  input logic                     rx_desc_ready_i,
  input logic [31:0]              rx_desc_i
);

  logic [3:0] fall_cnt_q;
  logic       byte_seen_q;

  // SCL falls since START, the first one is the START's own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fall_cnt_q <= '0;
    end else if (start_det_i || stop_det_i) begin
      fall_cnt_q <= '0;
    end else if (scl_fall_i && fall_cnt_q != 4'hf) begin
      fall_cnt_q <= fall_cnt_q + 4'd1;
    end
  end

  // Set by an accepted byte, cleared by an accepted descriptor
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_seen_q <= 1'b0;
    end else if (rx_desc_valid_i && rx_desc_ready_i) begin
      byte_seen_q <= 1'b0;
    end else if (rx_data_valid_i && rx_data_ready_i) begin
      byte_seen_q <= 1'b1;
    end
  end

  // Output ports hold valid and payload until accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_data_valid_i && !rx_data_ready_i |=> rx_data_valid_i && $stable(rx_data_i))
    else $error("data port dropped or changed before ready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_desc_valid_i && !rx_desc_ready_i |=> rx_desc_valid_i && $stable(rx_desc_i))
    else $error("descriptor port dropped or changed before ready");

  // SDA pulled low only between the 8th address fall and the 9th bit fall
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !sda_o_i |-> fall_cnt_q == 4'd9)
    else $error("sda_o low outside an ACK");

  // Bytes of a frame come before its descriptor
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_desc_valid_i |-> !rx_data_valid_i && byte_seen_q)
    else $error("descriptor with data valid or without a byte before it");

endmodule

bind i3c_target_rx i3c_target_rx_sva u_i3c_target_rx_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .sda_o_i        (sda_o),
  .scl_fall_i     (scl_fall),
  .start_det_i    (start_det),
  .stop_det_i     (stop_det),
  .rx_data_valid_i(rx_data_valid_o),
  .rx_data_ready_i(rx_data_ready_i),
  .rx_data_i      (rx_data_o),
  .rx_desc_valid_i(rx_desc_valid_o),
  .rx_desc_ready_i(rx_desc_ready_i),
  .rx_desc_i      (rx_desc_o)
);

// File: tests/i3c_target_rx_testdata.txt
// Per frame: addr rnw dav rstart hold tmask ack count flags nbytes, then nbytes data bytes
// flags bit0 parity error, bit1 overflow; tmask bit i corrupts the T bit of byte i; ff ends
3a 00 01 00 00 00 01 03 00 03  11 22 33
25 00 01 00 00 00 00 00 00 02  44 55
3a 01 01 00 00 00 00 00 00 01  66
3a 00 00 00 00 00 00 00 00 01  77
3a 00 01 00 00 02 01 03 01 03  a5 5a 0f
3a 00 01 01 00 00 01 02 00 02  01 02
3a 00 01 00 00 00 01 03 00 03  03 04 05
3a 00 01 00 01 00 01 0a 02 0c  80 81 82 83 84 85 86 87 88 89 8a 8b
3a 00 01 00 00 00 01 01 00 01  c3
ff

// File: tests/rx_checker.sv
// Compares accepted bytes and descriptors of the DUT against expectations from the test data
`timescale 1ns/100ps

module rx_checker (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        data_valid_i,
  input logic        data_ready_i,
  input logic [7:0]  data_i,
  input logic        desc_valid_i,
  input logic        desc_ready_i,
  input logic [31:0] desc_i
);

  logic [7:0]  td [0:255];
  logic [7:0]  exp_bytes [$];
  logic [31:0] exp_desc [$];
  int          err_cnt   = 0;
  int          desc_seen = 0;

  // Delivered bytes are the first count-1 sent plus the last one of the frame
  initial begin
    int p;
    int n;
    int cnt;
    $readmemh("tests/i3c_target_rx_testdata.txt", td);
    p = 0;
    while (td[p] !== 8'hff) begin
      n   = td[p+9];
      cnt = td[p+7];
      if (td[p+6] == 8'h01) begin
        for (int i = 0; i < cnt - 1; i++) begin
          exp_bytes.push_back(td[p+10+i]);
        end
        exp_bytes.push_back(td[p+9+n]);
        exp_desc.push_back({14'b0, td[p+8][1], td[p+8][0], 16'(cnt)});
      end
      p = p + 10 + n;
    end
  end

  always @(posedge clk_i) begin
    logic [7:0]  exp_b;
    logic [31:0] exp_d;
    if (rst_ni && data_valid_i && data_ready_i) begin
      if (exp_bytes.size() == 0) begin
        $display("Unexpected byte %h on the data port", data_i);
        err_cnt++;
      end else begin
        exp_b = exp_bytes.pop_front();
        if (data_i !== exp_b) begin
          $display("** Error rx_data_o: expected %h, got %h", exp_b, data_i);
          err_cnt++;
        end
      end
    end
    if (rst_ni && desc_valid_i && desc_ready_i) begin
      desc_seen++;
      if (exp_desc.size() == 0) begin
        $display("Unexpected descriptor %h on the descriptor port", desc_i);
        err_cnt++;
      end else begin
        exp_d = exp_desc.pop_front();
        if (desc_i !== exp_d) begin
          $display("** Error rx_desc_o: expected %h, got %h", exp_d, desc_i);
          err_cnt++;
        end
      end
    end
  end

endmodule

// File: tests/tb_i3c_target_rx.sv
// Testbench for the I3C target receive path, bit-bangs frames listed in the test data
`timescale 1ns/100ps
`include "i3c_rx_cfg.svh"

module tb_i3c_target_rx;

  localparam int HALF    = 8;
  localparam int TIMEOUT = 20000;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   scl;
  logic                   tb_sda;
  logic                   sda_o;
  logic                   sda_line;
  logic [`I3C_ADDR_W-1:0] dyn_addr;
  logic                   dyn_addr_valid;
  logic                   rx_data_valid;
  logic [`I3C_BYTE_W-1:0] rx_data;
  logic                   rx_data_ready;
  logic                   rx_desc_valid;
  logic [31:0]            rx_desc;
  logic                   rx_desc_ready;
  logic                   hold;
  logic [7:0]             td [0:255];
  logic [31:0]            rnd;
  integer                 seed = 32'h127b3670;
  int                     tb_errs = 0;
  int                     acked = 0;

  always #10 clk_i = ~clk_i;

  // Open-drain bus
  assign sda_line = tb_sda & sda_o;

  i3c_target_rx u_i3c_target_rx (
    .clk_i(clk_i), .rst_ni(rst_ni), .scl_i(scl), .sda_i(sda_line), .sda_o(sda_o),
    .dyn_addr_i(dyn_addr), .dyn_addr_valid_i(dyn_addr_valid),
    .rx_data_valid_o(rx_data_valid), .rx_data_o(rx_data), .rx_data_ready_i(rx_data_ready),
    .rx_desc_valid_o(rx_desc_valid), .rx_desc_o(rx_desc), .rx_desc_ready_i(rx_desc_ready)
  );

  rx_checker u_rx_checker (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .data_valid_i(rx_data_valid), .data_ready_i(rx_data_ready), .data_i(rx_data),
    .desc_valid_i(rx_desc_valid), .desc_ready_i(rx_desc_ready), .desc_i(rx_desc)
  );

  always @(posedge clk_i) begin
    rnd = $random(seed);
    rx_data_ready <= rnd[0] & ~hold;
    rx_desc_ready <= rnd[1];
  end

  task automatic clocks(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // SCL is low on entry and on exit of every bit
  task automatic drive_bit(input logic b);
    tb_sda <= b;
    clocks(HALF / 2);
    scl <= 1'b1;
    clocks(HALF);
    scl <= 1'b0;
    clocks(HALF / 2);
  endtask

  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      drive_bit(b[i]);
    end
  endtask

  // Also serves as repeated START when SCL is low
  task automatic send_start;
    tb_sda <= 1'b1;
    clocks(HALF / 2);
    scl <= 1'b1;
    clocks(HALF / 2);
    tb_sda <= 1'b0;
    clocks(HALF / 2);
    scl <= 1'b0;
    clocks(HALF / 2);
  endtask

  task automatic send_stop;
    tb_sda <= 1'b0;
    clocks(HALF / 2);
    scl <= 1'b1;
    clocks(HALF / 2);
    tb_sda <= 1'b1;
    clocks(HALF);
  endtask

  task automatic sample_ack(output logic seen);
    tb_sda <= 1'b1;
    clocks(HALF / 2);
    scl <= 1'b1;
    clocks(HALF / 2);
    seen = sda_line;
    clocks(HALF / 2);
    scl <= 1'b0;
    clocks(HALF / 2);
  endtask

  task automatic wait_drained;
    int t;
    t = 0;
    while (u_rx_checker.desc_seen != acked && t < TIMEOUT) begin
      clocks(1);
      t++;
    end
    if (t >= TIMEOUT) begin
      $display("Timeout waiting for %0d descriptors, saw %0d", acked, u_rx_checker.desc_seen);
      tb_errs++;
    end
  endtask

  initial begin
    int         p;
    int         n;
    logic       seen;
    logic       in_restart;
    logic [7:0] b;
    rst_ni = 1'b0;
    scl = 1'b1;
    tb_sda = 1'b1;
    dyn_addr = 7'h3a;
    dyn_addr_valid = 1'b0;
    hold = 1'b0;
    rx_data_ready = 1'b0;
    rx_desc_ready = 1'b0;
    in_restart = 1'b0;
    $readmemh("tests/i3c_target_rx_testdata.txt", td);
    clocks(5);
    rst_ni <= 1'b1;
    clocks(5);
    p = 0;
    while (td[p] !== 8'hff) begin
      n = td[p+9];
      if (!in_restart) begin
        wait_drained();
      end
      dyn_addr_valid <= td[p+2][0];
      hold <= td[p+4][0];
      send_start();
      send_byte({td[p][6:0], td[p+1][0]});
      sample_ack(seen);
      if (seen !== ~td[p+6][0]) begin
        $display("** Error sda ACK: expected %h, got %h", ~td[p+6][0], seen);
        tb_errs++;
      end
      for (int i = 0; i < n; i++) begin
        b = td[p+10+i];
        send_byte(b);
        // Odd parity over byte and T bit, flipped where the mask asks
        drive_bit(~(^b) ^ (i < 8 ? td[p+5][i] : 1'b0));
      end
      if (td[p+3][0] == 1'b0) begin
        send_stop();
        hold <= 1'b0;
      end
      in_restart = td[p+3][0];
      acked += td[p+6][0];
      p = p + 10 + n;
    end
    wait_drained();
    clocks(20);
    $display("Errors: testbench %0d, checker %0d", tb_errs, u_rx_checker.err_cnt);
    if (tb_errs + u_rx_checker.err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
